//--- sim.f
verilog/vis_pkg.sv
verilog/issue_fsm.sv
verilog/uop_counter.sv
verilog/scoreboard.sv
verilog/vreg_file.sv
verilog/operand_select.sv
verilog/vis_top.sv
sim/tb_vis.sv

//--- sim/tb_vis.sv
/*
 * Random testbench for vis_top with an in-order execution stage model.
 * Each uop result is op_a + op_b per lane, written back 0..7 cycles later.
 */
`timescale 1ns/10ps

module tb_vis;

    localparam int N_INSTR = 200;
    // 200 instructions, 4 uops each, about 25 cycles worst case per uop
    localparam int TIMEOUT = 20000;

    typedef struct {
        vis_pkg::vreg_addr_t dst;
        vis_pkg::lane_mask_t en;
        vis_pkg::ticket_t    ticket;
        vis_pkg::lane_data_t data;
        int                  due;
    } exec_entry_t;

    logic                clk;
    logic                rstn;
    logic                instr_valid;
    vis_pkg::vinstr_t    instr;
    logic                instr_ready;
    logic                uop_valid;
    vis_pkg::lane_mask_t lane_valid;
    vis_pkg::lane_data_t op_a;
    vis_pkg::lane_data_t op_b;
    vis_pkg::uop_info_t  info;
    logic                uop_ready;
    vis_pkg::wb_t        wb;
    logic                is_idle;

    // Model state
    vis_pkg::lane_data_t ref_regs [vis_pkg::VREGS];
    exec_entry_t         exec_q [$];
    exec_entry_t         ent;
    vis_pkg::vinstr_t    cur;
    logic                active;
    int                  uop_k;
    int                  sent;
    int                  gap;
    int                  cycles;
    int                  errors;
    logic                finished;
    logic                hold;
    vis_pkg::lane_mask_t hold_lanes;
    vis_pkg::lane_data_t hold_a;
    vis_pkg::lane_data_t hold_b;
    vis_pkg::uop_info_t  hold_info;

    vis_top u_vis_top (
        .clk_i        (clk),
        .rstn_i       (rstn),
        .valid_i      (instr_valid),
        .instr_i      (instr),
        .ready_o      (instr_ready),
        .valid_o      (uop_valid),
        .lane_valid_o (lane_valid),
        .op_a_o       (op_a),
        .op_b_o       (op_b),
        .info_o       (info),
        .ready_i      (uop_ready),
        .wb_i         (wb),
        .is_idle_o    (is_idle)
    );

    task automatic value_error(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        errors++;
        $display("ERROR %s: got %h expected %h at cycle %0d", name, got, exp, cycles);
    endtask

    task automatic plain_error(input string what);
        errors++;
        $display("Cycle %0d: %s", cycles, what);
    endtask

    // Reference value, with a same-cycle writeback already included
    function automatic vis_pkg::elem_t read_ref(input vis_pkg::vreg_addr_t r, input int l);
        if (wb.en[l] && wb.addr == r) begin
            return wb.data[l];
        end
        return ref_regs[r][l];
    endfunction

    function automatic vis_pkg::vinstr_t random_instr();
        vis_pkg::vinstr_t i;
        i.funct6 = 6'($urandom);
        i.kind   = vis_pkg::operand_kind_e'($urandom % 3);
        // Narrow base range so that registers overlap often
        i.dst    = vis_pkg::vreg_addr_t'($urandom % 4);
        i.src1   = vis_pkg::vreg_addr_t'($urandom % 4);
        i.src2   = vis_pkg::vreg_addr_t'($urandom % 4);
        i.vl     = vis_pkg::vl_t'(1 + $urandom % vis_pkg::MAX_VL);
        i.ticket = vis_pkg::ticket_t'($urandom);
        i.scalar = $urandom;
        i.imm    = 5'($urandom);
        return i;
    endfunction

    // ========================================
    // Uop checks and execution queue
    // ========================================
    task automatic check_uop();
        vis_pkg::vreg_addr_t dst_k;
        vis_pkg::vreg_addr_t src_a;
        vis_pkg::vreg_addr_t src_b;
        vis_pkg::lane_mask_t exp_lanes;
        vis_pkg::elem_t      ea;
        vis_pkg::elem_t      eb;
        exec_entry_t         e;
        logic                conflict;
        int                  left;
        left  = int'(cur.vl) - uop_k * vis_pkg::LANES;
        dst_k = vis_pkg::vreg_addr_t'((int'(cur.dst) + uop_k) % vis_pkg::VREGS);
        src_a = vis_pkg::vreg_addr_t'((int'(cur.src1) + uop_k) % vis_pkg::VREGS);
        src_b = vis_pkg::vreg_addr_t'((int'(cur.src2) + uop_k) % vis_pkg::VREGS);
        for (int l = 0; l < vis_pkg::LANES; l++) begin
            exp_lanes[l] = (l < left);
        end
        assert (lane_valid == exp_lanes) else value_error("lane_valid_o", lane_valid, exp_lanes);
        assert (info.head_uop == (uop_k == 0))
            else value_error("info_o.head_uop", info.head_uop, uop_k == 0);
        assert (info.last_uop == (left <= vis_pkg::LANES))
            else value_error("info_o.last_uop", info.last_uop, left <= vis_pkg::LANES);
        assert (int'(info.vl_left) == left) else value_error("info_o.vl_left", info.vl_left, left);
        assert (info.dst == dst_k) else value_error("info_o.dst", info.dst, dst_k);
        assert (info.ticket == cur.ticket) else value_error("info_o.ticket", info.ticket, cur.ticket);
        assert (info.funct6 == cur.funct6)
            else value_error("info_o.funct6", info.funct6, cur.funct6);

        // Outstanding results still block sources and destination
        conflict = 1'b0;
        foreach (exec_q[i]) begin
            if (|(exec_q[i].en & exp_lanes)) begin
                if (exec_q[i].dst == dst_k || exec_q[i].dst == src_b
                    || (cur.kind == vis_pkg::VV && exec_q[i].dst == src_a)) begin
                    conflict = 1'b1;
                end
            end
        end
        assert (!conflict) else plain_error("uop issued over a result not yet written back");

        e.dst    = dst_k;
        e.en     = exp_lanes;
        e.ticket = cur.ticket;
        e.due    = cycles + int'($urandom % 8);
        for (int l = 0; l < vis_pkg::LANES; l++) begin
            case (cur.kind)
                // Immediate range is -16..15
                vis_pkg::VI: ea = vis_pkg::elem_t'(int'(cur.imm) - (cur.imm[4] ? 32 : 0));
                vis_pkg::VX: ea = cur.scalar;
                default:     ea = read_ref(src_a, l);
            endcase
            eb = read_ref(src_b, l);
            if (exp_lanes[l]) begin
                assert (op_a[l] == ea) else value_error("op_a_o", op_a[l], ea);
                assert (op_b[l] == eb) else value_error("op_b_o", op_b[l], eb);
            end
            e.data[l] = exp_lanes[l] ? ea + eb : '0;
        end
        exec_q.push_back(e);

        if (left <= vis_pkg::LANES) begin
            active = 1'b0;
        end else begin
            uop_k++;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ========================================
    // Stimulus, model and checks per edge
    // ========================================
    always @(posedge clk) begin
        if (rstn) begin
            cycles++;
            uop_ready <= ($urandom % 4) != 0;

            // Held outputs under backpressure
            if (hold) begin
                assert (uop_valid && lane_valid == hold_lanes && op_a == hold_a
                        && op_b == hold_b && info == hold_info)
                    else plain_error("uop outputs changed while ready_i was low");
            end
            hold       = uop_valid && !uop_ready;
            hold_lanes = lane_valid;
            hold_a     = op_a;
            hold_b     = op_b;
            hold_info  = info;

            assert (!(instr_ready && active)) else plain_error("ready_o high during an instruction");
            assert (!(is_idle && (active || exec_q.size() > 0)))
                else plain_error("is_idle_o high with work outstanding");

            if (uop_valid && uop_ready) begin
                if (active) begin
                    check_uop();
                end else begin
                    plain_error("uop transferred with no instruction in flight");
                end
            end

            if (instr_valid && instr_ready) begin
                cur         = instr;
                active      = 1'b1;
                uop_k       = 0;
                sent++;
                instr_valid <= 1'b0;
                gap         = int'($urandom % 4);
            end else if (!instr_valid && sent < N_INSTR) begin
                if (gap > 0) begin
                    gap--;
                end else begin
                    instr       <= random_instr();
                    instr_valid <= 1'b1;
                end
            end

            // All issued work retired and no writeback in flight
            if (!finished && sent == N_INSTR && !active && !instr_valid
                && exec_q.size() == 0 && wb.en == '0) begin
                assert (is_idle) else plain_error("is_idle_o low after the last writeback");
                finished = 1'b1;
            end

            for (int l = 0; l < vis_pkg::LANES; l++) begin
                if (wb.en[l]) begin
                    ref_regs[wb.addr][l] = wb.data[l];
                end
            end
            // One writeback per cycle, in issue order
            if (exec_q.size() > 0 && exec_q[0].due <= cycles) begin
                ent = exec_q.pop_front();
                wb  <= {ent.en, ent.dst, ent.ticket, ent.data};
            end else begin
                wb <= '0;
            end
        end
    end

    initial begin
        void'($urandom(44));
        rstn        = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        uop_ready   = 1'b0;
        wb          = '0;
        active      = 1'b0;
        uop_k       = 0;
        sent        = 0;
        gap         = 0;
        cycles      = 0;
        errors      = 0;
        finished    = 1'b0;
        hold        = 1'b0;
        foreach (ref_regs[r]) begin
            ref_regs[r] = '0;
        end
        repeat (10) @(posedge clk);
        assert (!instr_ready && !uop_valid && lane_valid == '0)
            else plain_error("ready_o, valid_o or lane_valid_o high in reset");
        rstn <= 1'b1;

        wait (finished || cycles >= TIMEOUT);
        if (!finished) begin
            errors++;
            $display("Timeout after %0d cycles, %0d of %0d instructions accepted",
                     cycles, sent, N_INSTR);
        end
        $display("Errors: %0d, instructions: %0d, cycles: %0d", errors, sent, cycles);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- verilog/issue_fsm.sv
/*
 * Holds one instruction at a time; ready_o is registered and low in reset.
 * valid_o stays up under backpressure since writebacks only remove hazards.
 */
`timescale 1ns/10ps

module issue_fsm (
    input  logic                   clk_i,
    input  logic                   rstn_i,
    input  logic                   valid_i,
    input  vis_pkg::vinstr_t       instr_i,
    output logic                   ready_o,
    input  logic                   ready_i,
    input  logic                   hazard_free_i,
    input  logic                   last_uop_i,
    output logic                   valid_o,
    output logic                   issue_go_o,
    output vis_pkg::vinstr_t       cur_instr_o,
    output vis_pkg::issue_state_e  state_o
);

    vis_pkg::issue_state_e state_q;
    vis_pkg::issue_state_e state_d;
    logic                  ready_q;
    logic                  accept;
    vis_pkg::vinstr_t      cur_instr_q;

    assign accept     = valid_i & ready_o;
    assign valid_o    = (state_q == vis_pkg::S_ISSUE) & hazard_free_i;
    assign issue_go_o = valid_o & ready_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            vis_pkg::S_IDLE: begin
                if (accept) begin
                    state_d = vis_pkg::S_ISSUE;
                end
            end
            vis_pkg::S_ISSUE: begin
                // Leave once the final uop has been taken
                if (issue_go_o && last_uop_i) begin
                    state_d = vis_pkg::S_IDLE;
                end
            end
            default: state_d = vis_pkg::S_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q <= vis_pkg::S_IDLE;
            ready_q <= 1'b0;
        end else begin
            state_q <= state_d;
            ready_q <= (state_d == vis_pkg::S_IDLE);
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            cur_instr_q <= instr_i;
        end
    end

    assign ready_o     = ready_q;
    assign cur_instr_o = cur_instr_q;
    assign state_o     = state_q;

    a_vl_range: assert property (@(posedge clk_i) disable iff (!rstn_i)
        accept |-> (instr_i.vl >= 1) && (instr_i.vl <= vis_pkg::MAX_VL));

    // Scoreboard may only release hazards while a uop waits
    a_valid_hold: assert property (@(posedge clk_i) disable iff (!rstn_i)
        valid_o && !ready_i |=> valid_o);

endmodule

//--- verilog/operand_select.sv
/*
 * Per-lane operand mux; purely combinational.
 * Forward masks must already be qualified by pending bits and ticket.
 */
`timescale 1ns/10ps

module operand_select (
    input  vis_pkg::vinstr_t     cur_instr_i,
    input  vis_pkg::lane_data_t  rd_data_a_i,
    input  vis_pkg::lane_data_t  rd_data_b_i,
    input  vis_pkg::lane_mask_t  fwd_a_i,
    input  vis_pkg::lane_mask_t  fwd_b_i,
    input  vis_pkg::wb_t         wb_i,
    input  vis_pkg::lane_mask_t  lane_therm_i,
    input  logic                 uop_valid_i,
    output vis_pkg::lane_data_t  op_a_o,
    output vis_pkg::lane_data_t  op_b_o,
    output vis_pkg::lane_mask_t  lane_valid_o
);

    vis_pkg::elem_t imm_ext;

    // Sign-extended 5-bit immediate
    assign imm_ext = {{(vis_pkg::DATA_W - 5){cur_instr_i.imm[4]}}, cur_instr_i.imm};

    always_comb begin
        for (int l = 0; l < vis_pkg::LANES; l++) begin
            case (cur_instr_i.kind)
                vis_pkg::VI: op_a_o[l] = imm_ext;
                vis_pkg::VX: op_a_o[l] = cur_instr_i.scalar;
                default: begin
                    op_a_o[l] = fwd_a_i[l] ? wb_i.data[l] : rd_data_a_i[l];
                end
            endcase
            op_b_o[l] = fwd_b_i[l] ? wb_i.data[l] : rd_data_b_i[l];
        end
    end

    assign lane_valid_o = lane_therm_i & {vis_pkg::LANES{uop_valid_i}};

endmodule

//--- verilog/scoreboard.sv
/*
 * Pending bits per register and lane, one ticket per register.
 * A destination must be idle in every lane before issue, so WAW stalls.
 */
`timescale 1ns/10ps

module scoreboard (
    input  logic                  clk_i,
    input  logic                  rstn_i,
    input  vis_pkg::vinstr_t      cur_instr_i,
    input  vis_pkg::uop_idx_t     uop_idx_i,
    input  vis_pkg::lane_mask_t   lane_therm_i,
    input  logic                  issue_go_i,
    input  vis_pkg::wb_t          wb_i,
    output vis_pkg::vreg_addr_t   rd_addr_a_o,
    output vis_pkg::vreg_addr_t   rd_addr_b_o,
    output vis_pkg::vreg_addr_t   dst_o,
    output vis_pkg::lane_mask_t   fwd_a_o,
    output vis_pkg::lane_mask_t   fwd_b_o,
    output logic                  hazard_free_o,
    output logic                  any_pending_o
);

    vis_pkg::lane_mask_t [vis_pkg::VREGS-1:0] pending_q;
    vis_pkg::lane_mask_t [vis_pkg::VREGS-1:0] pending_d;
    vis_pkg::ticket_t                         ticket_q [vis_pkg::VREGS];

    logic                wb_tkt_hit;
    vis_pkg::lane_mask_t wb_clr;
    vis_pkg::lane_mask_t src_a_ok;
    vis_pkg::lane_mask_t src_b_ok;
    vis_pkg::lane_mask_t lane_ok;
    logic                dst_idle;

    // ========================================
    // Register indices of this uop
    // ========================================
    assign rd_addr_a_o = cur_instr_i.src1 + vis_pkg::vreg_addr_t'(uop_idx_i);
    assign rd_addr_b_o = cur_instr_i.src2 + vis_pkg::vreg_addr_t'(uop_idx_i);
    assign dst_o       = cur_instr_i.dst  + vis_pkg::vreg_addr_t'(uop_idx_i);

    // Writeback lanes that retire a pending result
    assign wb_tkt_hit = (wb_i.ticket == ticket_q[wb_i.addr]);
    assign wb_clr     = wb_i.en & pending_q[wb_i.addr] & {vis_pkg::LANES{wb_tkt_hit}};

    assign fwd_a_o = wb_clr & {vis_pkg::LANES{wb_i.addr == rd_addr_a_o}};
    assign fwd_b_o = wb_clr & {vis_pkg::LANES{wb_i.addr == rd_addr_b_o}};

    // ========================================
    // Hazard check
    // ========================================
    assign src_a_ok = (cur_instr_i.kind != vis_pkg::VV) ? '1
                    : (~pending_q[rd_addr_a_o] | fwd_a_o);
    assign src_b_ok = ~pending_q[rd_addr_b_o] | fwd_b_o;

    // Whole register, as it carries a single ticket
    assign dst_idle = ~|pending_q[dst_o];

    assign lane_ok       = src_a_ok & src_b_ok & {vis_pkg::LANES{dst_idle}};
    assign hazard_free_o = &(lane_ok | ~lane_therm_i);
    assign any_pending_o = |pending_q;

    // ========================================
    // Pending state
    // ========================================
    always_comb begin
        pending_d = pending_q;
        pending_d[wb_i.addr] = pending_q[wb_i.addr] & ~wb_clr;
        if (issue_go_i) begin
            pending_d[dst_o] = pending_d[dst_o] | lane_therm_i;
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            pending_q <= '0;
        end else begin
            pending_q <= pending_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (issue_go_i) begin
            ticket_q[dst_o] <= cur_instr_i.ticket;
        end
    end

    // Execution stage writes back only what was issued to it
    a_wb_pending: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (|wb_i.en) && wb_tkt_hit |-> (wb_i.en & ~pending_q[wb_i.addr]) == '0);

endmodule

//--- verilog/uop_counter.sv
/*
 * Counts issued uops of the current instruction.
 * Outputs are combinational from the index and vl_i.
 */
`timescale 1ns/10ps

module uop_counter (
    input  logic                 clk_i,
    input  logic                 rstn_i,
    input  logic                 issue_go_i,
    input  vis_pkg::vl_t         vl_i,
    output vis_pkg::uop_idx_t    uop_idx_o,
    output vis_pkg::lane_mask_t  lane_therm_o,
    output logic                 last_uop_o,
    output vis_pkg::vl_t         vl_left_o
);

    vis_pkg::uop_idx_t idx_q;

    // Elements not yet covered by earlier uops
    assign vl_left_o = vl_i - vis_pkg::vl_t'(idx_q) * vis_pkg::vl_t'(vis_pkg::LANES);

    // Next index would reach vl
    assign last_uop_o = (vl_left_o <= vis_pkg::vl_t'(vis_pkg::LANES));

    always_comb begin
        for (int l = 0; l < vis_pkg::LANES; l++) begin
            lane_therm_o[l] = (vl_left_o > vis_pkg::vl_t'(l));
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            idx_q <= '0;
        end else if (issue_go_i) begin
            if (last_uop_o) begin
                idx_q <= '0;
            end else begin
                idx_q <= idx_q + 1'b1;
            end
        end
    end

    assign uop_idx_o = idx_q;

    // A vl above MAX_VL would wrap the index
    a_idx_limit: assert property (@(posedge clk_i) disable iff (!rstn_i)
        issue_go_i && !last_uop_o |-> int'(idx_q) < vis_pkg::MAX_UOPS - 1);

endmodule

//--- verilog/vis_pkg.sv
/*
 * Sizes and shared types of the vector issue stage.
 * Register indices wrap modulo VREGS; vl must lie in 1..MAX_VL.
 */
package vis_pkg;

    // ========================================
    // Sizes
    // ========================================
    localparam int VREGS    = 8;
    localparam int LANES    = 4;
    localparam int DATA_W   = 32;
    localparam int TICKET_W = 4;
    localparam int MAX_UOPS = 4;
    localparam int MAX_VL   = LANES * MAX_UOPS;

    localparam int VREG_W = $clog2(VREGS);
    localparam int UOP_W  = $clog2(MAX_UOPS);
    // One extra bit so that MAX_VL itself fits
    localparam int VL_W   = $clog2(MAX_VL + 1);

    // ========================================
    // Vector types
    // ========================================
    typedef logic [VREG_W-1:0]   vreg_addr_t;
    typedef logic [TICKET_W-1:0] ticket_t;
    typedef logic [VL_W-1:0]     vl_t;
    typedef logic [UOP_W-1:0]    uop_idx_t;
    typedef logic [LANES-1:0]    lane_mask_t;
    typedef logic [DATA_W-1:0]   elem_t;
    typedef elem_t [LANES-1:0]   lane_data_t;

    // Source of the first operand
    typedef enum logic [1:0] {
        VV,
        VX,
        VI
    } operand_kind_e;

    typedef enum logic {
        S_IDLE,
        S_ISSUE
    } issue_state_e;

    // ========================================
    // Bundles
    // ========================================
    typedef struct packed {
        logic [5:0]    funct6;
        operand_kind_e kind;
        vreg_addr_t    dst;
        vreg_addr_t    src1;
        vreg_addr_t    src2;
        vl_t           vl;
        ticket_t       ticket;
        elem_t         scalar;
        logic [4:0]    imm;
    } vinstr_t;

    // Control that travels with each uop
    typedef struct packed {
        logic [5:0] funct6;
        vreg_addr_t dst;
        ticket_t    ticket;
        logic       head_uop;
        logic       last_uop;
        vl_t        vl_left;
    } uop_info_t;

    typedef struct packed {
        lane_mask_t en;
        vreg_addr_t addr;
        ticket_t    ticket;
        lane_data_t data;
    } wb_t;

endpackage

//--- verilog/vis_top.sv
/*
 * Vector issue stage: one instruction in flight, uops issued in order.
 * The writeback port must only return issued uops, one per cycle.
 */
`timescale 1ns/10ps

module vis_top (
    input  logic                  clk_i,
    input  logic                  rstn_i,
    // Instruction in
    input  logic                  valid_i,
    input  vis_pkg::vinstr_t      instr_i,
    output logic                  ready_o,
    // Uops out
    output logic                  valid_o,
    output vis_pkg::lane_mask_t   lane_valid_o,
    output vis_pkg::lane_data_t   op_a_o,
    output vis_pkg::lane_data_t   op_b_o,
    output vis_pkg::uop_info_t    info_o,
    input  logic                  ready_i,
    // Writeback
    input  vis_pkg::wb_t          wb_i,
    output logic                  is_idle_o
);

    vis_pkg::vinstr_t      cur_instr;
    vis_pkg::issue_state_e state;
    logic                  issue_go;
    logic                  hazard_free;
    logic                  last_uop;
    logic                  any_pending;
    vis_pkg::uop_idx_t     uop_idx;
    vis_pkg::lane_mask_t   lane_therm;
    vis_pkg::vl_t          vl_left;
    vis_pkg::vreg_addr_t   rd_addr_a;
    vis_pkg::vreg_addr_t   rd_addr_b;
    vis_pkg::vreg_addr_t   dst;
    vis_pkg::lane_mask_t   fwd_a;
    vis_pkg::lane_mask_t   fwd_b;
    vis_pkg::lane_data_t   rd_data_a;
    vis_pkg::lane_data_t   rd_data_b;

    issue_fsm u_issue_fsm (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .valid_i       (valid_i),
        .instr_i       (instr_i),
        .ready_o       (ready_o),
        .ready_i       (ready_i),
        .hazard_free_i (hazard_free),
        .last_uop_i    (last_uop),
        .valid_o       (valid_o),
        .issue_go_o    (issue_go),
        .cur_instr_o   (cur_instr),
        .state_o       (state)
    );

    uop_counter u_uop_counter (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .issue_go_i   (issue_go),
        .vl_i         (cur_instr.vl),
        .uop_idx_o    (uop_idx),
        .lane_therm_o (lane_therm),
        .last_uop_o   (last_uop),
        .vl_left_o    (vl_left)
    );

    scoreboard u_scoreboard (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .cur_instr_i   (cur_instr),
        .uop_idx_i     (uop_idx),
        .lane_therm_i  (lane_therm),
        .issue_go_i    (issue_go),
        .wb_i          (wb_i),
        .rd_addr_a_o   (rd_addr_a),
        .rd_addr_b_o   (rd_addr_b),
        .dst_o         (dst),
        .fwd_a_o       (fwd_a),
        .fwd_b_o       (fwd_b),
        .hazard_free_o (hazard_free),
        .any_pending_o (any_pending)
    );

    vreg_file u_vreg_file (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .rd_addr_a_i (rd_addr_a),
        .rd_addr_b_i (rd_addr_b),
        .rd_data_a_o (rd_data_a),
        .rd_data_b_o (rd_data_b),
        .wb_i        (wb_i)
    );

    operand_select u_operand_select (
        .cur_instr_i  (cur_instr),
        .rd_data_a_i  (rd_data_a),
        .rd_data_b_i  (rd_data_b),
        .fwd_a_i      (fwd_a),
        .fwd_b_i      (fwd_b),
        .wb_i         (wb_i),
        .lane_therm_i (lane_therm),
        .uop_valid_i  (valid_o),
        .op_a_o       (op_a_o),
        .op_b_o       (op_b_o),
        .lane_valid_o (lane_valid_o)
    );

    // ========================================
    // Uop control
    // ========================================
    assign info_o.funct6   = cur_instr.funct6;
    assign info_o.dst      = dst;
    assign info_o.ticket   = cur_instr.ticket;
    assign info_o.head_uop = (uop_idx == '0);
    assign info_o.last_uop = last_uop;
    assign info_o.vl_left  = vl_left;

    assign is_idle_o = (state == vis_pkg::S_IDLE) & ~any_pending;

endmodule

//--- verilog/vreg_file.sv
/*
 * Lane-organized register file, cleared by reset.
 * Reads are combinational; a write lands at the next clock edge.
 */
`timescale 1ns/10ps

module vreg_file (
    input  logic                 clk_i,
    input  logic                 rstn_i,
    input  vis_pkg::vreg_addr_t  rd_addr_a_i,
    input  vis_pkg::vreg_addr_t  rd_addr_b_i,
    output vis_pkg::lane_data_t  rd_data_a_o,
    output vis_pkg::lane_data_t  rd_data_b_o,
    input  vis_pkg::wb_t         wb_i
);

    vis_pkg::lane_data_t regs_q [vis_pkg::VREGS];

    assign rd_data_a_o = regs_q[rd_addr_a_i];
    assign rd_data_b_o = regs_q[rd_addr_b_i];

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            for (int r = 0; r < vis_pkg::VREGS; r++) begin
                regs_q[r] <= '0;
            end
        end else begin
            // Per-lane write enables
            for (int l = 0; l < vis_pkg::LANES; l++) begin
                if (wb_i.en[l]) begin
                    regs_q[wb_i.addr][l] <= wb_i.data[l];
                end
            end
        end
    end

endmodule
